//--- hdl/csam_pkg.sv
package csam_pkg;

   // ------------------------------
   // widths
   // ------------------------------

   // operand width, everything else follows from it
   localparam int op_w = 16;

   // full product width
   localparam int prod_w = 2 * op_w;

   // ------------------------------
   // stage payloads
   // ------------------------------

   // operand pair at the input
   typedef struct packed {
      logic [op_w-1:0] a;
      logic [op_w-1:0] b;
   } mul_req_t;

   // carry-save state after the last reduction row
   // low_bits holds finished product bits 15..0
   // sum_row holds last-row sum bits 15..1
   // carry_row holds last-row carry bits 14..0
   typedef struct packed {
      logic [op_w-1:0] low_bits;
      logic [op_w-2:0] sum_row;
      logic [op_w-2:0] carry_row;
   } csa_vec_t;

   // final result
   // sat_low is all ones when any upper product bit is set
   typedef struct packed {
      logic [prod_w-1:0] product;
      logic [op_w-1:0]   sat_low;
      logic              overflow;
   } mul_rsp_t;

endpackage

//--- hdl/csa_array.sv
`timescale 1ns/1ps

module csa_array (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               in_valid,
   input  csam_pkg::mul_req_t req,
   output logic               csa_valid,
   output csam_pkg::csa_vec_t csa
);

   import csam_pkg::*;

   // pp[j][i] is a[i] and b[j]
   logic [op_w-1:0] pp [op_w];

   // finished product bits, one per row
   logic [op_w-1:0] low_bits;

   csa_vec_t csa_next;

   genvar gi;
   genvar gj;
   genvar gk;

   // ------------------------------
   // partial-product matrix
   // ------------------------------

   generate
      for (gj = 0; gj < op_w; gj++) begin : g_pp_row
         for (gi = 0; gi < op_w; gi++) begin : g_pp_bit
            assign pp[gj][gi] = req.a[gi] & req.b[gj];
         end
      end
   endgenerate

   // row 0 is taken as is
   assign low_bits[0] = pp[0][0];

   // ------------------------------
   // carry-save reduction
   // ------------------------------

   // each row k adds partial product row k to the shifted sum of
   // row k-1 and the unshifted carry of row k-1
   generate
      for (gk = 1; gk < op_w; gk++) begin : g_row
         logic [op_w-1:0] s;
         logic [op_w-2:0] c;

         // top bit of each row has nothing to add yet
         assign s[op_w-1] = pp[gk][op_w-1];

         for (gi = 0; gi < op_w-1; gi++) begin : g_cell
            if (gk == 1) begin : g_ha
               // first row, no incoming carry
               assign s[gi] = pp[1][gi] ^ pp[0][gi+1];
               assign c[gi] = pp[1][gi] & pp[0][gi+1];
            end else begin : g_fa
               logic x;
               logic y;
               logic z;

               assign x = pp[gk][gi];
               assign y = g_row[gk-1].s[gi+1];
               assign z = g_row[gk-1].c[gi];

               assign s[gi] = x ^ y ^ z;
               assign c[gi] = (x & y) | (x & z) | (y & z);
            end
         end

         // lsb of the row sum is final
         assign low_bits[gk] = s[0];
      end
   endgenerate

   // ------------------------------
   // stage-one register
   // ------------------------------

   always_comb begin
      csa_next.low_bits  = low_bits;
      csa_next.sum_row   = g_row[op_w-1].s[op_w-1:1];
      csa_next.carry_row = g_row[op_w-1].c;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         csa_valid <= 1'b0;
         csa       <= '0;
      end else begin
         csa_valid <= in_valid;
         // hold payload between strobes
         if (in_valid) begin
            csa <= csa_next;
         end
      end
   end

endmodule

//--- hdl/cpa_saturate.sv
`timescale 1ns/1ps

module cpa_saturate (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               csa_valid,
   input  csam_pkg::csa_vec_t csa,
   output logic               out_valid,
   output csam_pkg::mul_rsp_t rsp
);

   import csam_pkg::*;

   // product bits 31..16
   logic [op_w-1:0] upper;

   logic [prod_w-1:0] product;
   logic              overflow;
   logic [op_w-1:0]   sat_low;

   mul_rsp_t rsp_next;

   // ------------------------------
   // ripple carry-propagate add
   // ------------------------------

   // carry_row[i] and sum_row[i] both weigh bit 16+i
   always_comb begin : ripple
      logic cy;
      logic p;

      // half adder at bit 16
      upper[0] = csa.carry_row[0] ^ csa.sum_row[0];
      cy       = csa.carry_row[0] & csa.sum_row[0];

      // full adders for bits 17..30
      for (int i = 1; i < op_w-1; i++) begin
         p        = csa.carry_row[i] ^ csa.sum_row[i];
         upper[i] = p ^ cy;
         cy       = (csa.carry_row[i] & csa.sum_row[i]) | (p & cy);
      end

      // carry out is the msb
      upper[op_w-1] = cy;
   end

   // ------------------------------
   // overflow and saturation
   // ------------------------------

   assign product  = {upper, csa.low_bits};
   assign overflow = |upper;

   // clamp to 16 bits
   assign sat_low = overflow ? '1 : csa.low_bits;

   always_comb begin
      rsp_next.product  = product;
      rsp_next.sat_low  = sat_low;
      rsp_next.overflow = overflow;
   end

   // ------------------------------
   // output register
   // ------------------------------

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
         rsp       <= '0;
      end else begin
         out_valid <= csa_valid;
         if (csa_valid) begin
            rsp <= rsp_next;
         end
      end
   end

endmodule

//--- hdl/csam_mul.sv
`timescale 1ns/1ps

module csam_mul (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               in_valid,
   input  csam_pkg::mul_req_t req,
   output logic               out_valid,
   output csam_pkg::mul_rsp_t rsp
);

   import csam_pkg::*;

   // ------------------------------
   // stage boundary
   // ------------------------------

   logic     csa_valid;
   csa_vec_t csa;

   // stage one, partial products and carry-save rows
   csa_array u_csa_array (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .req       (req),
      .csa_valid (csa_valid),
      .csa       (csa)
   );

   // stage two, final add and saturation
   cpa_saturate u_cpa_saturate (
      .clk       (clk),
      .rst_n     (rst_n),
      .csa_valid (csa_valid),
      .csa       (csa),
      .out_valid (out_valid),
      .rsp       (rsp)
   );

endmodule

//--- testbench/csam_checker.sv
`timescale 1ns/1ps

module csam_checker (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          in_valid,
   input  csam_pkg::mul_req_t            req,
   input  logic [8*12-1:0]               name,
   input  logic [csam_pkg::prod_w-1:0]   ref_prod,
   input  logic                          ref_given,
   input  logic                          out_valid,
   input  csam_pkg::mul_rsp_t            rsp,
   input  logic                          end_of_test,
   output int                            value_errs,
   output int                            proto_errs,
   output int                            pending
);

   import csam_pkg::*;

   typedef struct packed {
      logic [8*12-1:0]   name;
      logic [prod_w-1:0] product;
      logic [op_w-1:0]   sat_low;
      logic              overflow;
      int                cyc;
   } expect_t;

   expect_t exp_q[$];
   int      cyc;
   logic    closed;

   // table product if given, otherwise plain a times b
   function automatic expect_t predict(input mul_req_t r, input logic [8*12-1:0] nm,
                                       input logic [prod_w-1:0] rp, input logic given,
                                       input int c);
      expect_t p;
      logic [prod_w-1:0] prod;
      if (given) begin
         prod = rp;
      end else begin
         prod = {{op_w{1'b0}}, r.a} * {{op_w{1'b0}}, r.b};
      end
      p.name     = nm;
      p.product  = prod;
      p.overflow = (prod[prod_w-1:op_w] != '0);
      p.sat_low  = p.overflow ? '1 : prod[op_w-1:0];
      p.cyc      = c;
      return p;
   endfunction

   always @(posedge clk) begin
      expect_t e;
      if (!rst_n) begin
         cyc        = 0;
         value_errs = 0;
         proto_errs = 0;
         closed     = 1'b0;
         exp_q.delete();
      end else begin
         cyc = cyc + 1;
         // outputs seen here were registered at the previous edge
         if (out_valid) begin
            if (exp_q.size() == 0) begin
               $display("out_valid came with no request pending");
               proto_errs++;
            end else begin
               e = exp_q.pop_front();
               if (rsp.product !== e.product) begin
                  $display("Error %0s: product expected %h actual %h",
                           e.name, e.product, rsp.product);
                  value_errs++;
               end
               if (rsp.overflow !== e.overflow) begin
                  $display("Error %0s: overflow expected %b actual %b",
                           e.name, e.overflow, rsp.overflow);
                  value_errs++;
               end
               if (rsp.sat_low !== e.sat_low) begin
                  $display("Error %0s: sat_low expected %h actual %h",
                           e.name, e.sat_low, rsp.sat_low);
                  value_errs++;
               end
               // strobe edge to the edge that sees the result
               if (cyc - e.cyc != 2) begin
                  $display("result for %0s came %0d cycles after its strobe instead of 2",
                           e.name, cyc - e.cyc);
                  proto_errs++;
               end
            end
         end
         if (in_valid) begin
            exp_q.push_back(predict(req, name, ref_prod, ref_given, cyc));
         end
         if (end_of_test && !closed) begin
            closed = 1'b1;
            if (exp_q.size() != 0) begin
               $display("%0d results never came out of the DUT", exp_q.size());
               proto_errs++;
            end
         end
      end
      pending = exp_q.size();
   end

endmodule

//--- testbench/csam_mul_sva.sv
`timescale 1ns/1ps

module csam_mul_sva (
   input logic               clk,
   input logic               rst_n,
   input logic               in_valid,
   input logic               out_valid,
   input csam_pkg::mul_rsp_t rsp
);

   // ------------------------------
   // pipeline timing
   // ------------------------------

   a_latency: assert property (@(posedge clk) disable iff (!rst_n)
      in_valid |-> ##2 out_valid)
      else $error("out_valid did not follow in_valid after two cycles");

   // no result without a strobe two edges back
   a_no_spurious: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid |-> $past(in_valid, 2))
      else $error("out_valid raised without a strobe two cycles before");

   // ------------------------------
   // response contents
   // ------------------------------

   a_saturate: assert property (@(posedge clk) disable iff (!rst_n)
      rsp.overflow |-> (rsp.sat_low == '1))
      else $error("overflow set but sat_low is not all ones");

   a_known: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid |-> !$isunknown(rsp))
      else $error("rsp has unknown bits while out_valid is high");

endmodule

bind csam_mul csam_mul_sva u_sva (
   .clk       (clk),
   .rst_n     (rst_n),
   .in_valid  (in_valid),
   .out_valid (out_valid),
   .rsp       (rsp)
);

//--- testbench/tb_csam_mul.sv
`timescale 1ns/1ps

module tb_csam_mul;

   import csam_pkg::*;

   // one stimulus entry, exp is only used when has_exp is set
   typedef struct packed {
      logic [8*12-1:0]   name;
      logic [op_w-1:0]   a;
      logic [op_w-1:0]   b;
      logic [prod_w-1:0] exp;
      logic              has_exp;
      logic [3:0]        gap;
   } stim_t;

   logic     clk = 1'b0;
   logic     rst_n;
   logic     in_valid;
   mul_req_t req;
   logic     out_valid;
   mul_rsp_t rsp;

   logic [8*12-1:0]   cur_name;
   logic [prod_w-1:0] ref_prod;
   logic              ref_given;
   logic              end_of_test;

   int value_errs;
   int proto_errs;
   int pending;

   stim_t stims[$];
   int    seed = 56535;
   int    limit_cycles = 0;

   always #5 clk = ~clk;

   csam_mul UUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .req       (req),
      .out_valid (out_valid),
      .rsp       (rsp)
   );

   csam_checker u_checker (
      .clk         (clk),
      .rst_n       (rst_n),
      .in_valid    (in_valid),
      .req         (req),
      .name        (cur_name),
      .ref_prod    (ref_prod),
      .ref_given   (ref_given),
      .out_valid   (out_valid),
      .rsp         (rsp),
      .end_of_test (end_of_test),
      .value_errs  (value_errs),
      .proto_errs  (proto_errs),
      .pending     (pending)
   );

   function automatic stim_t entry(input logic [8*12-1:0] name, input logic [op_w-1:0] a,
                                   input logic [op_w-1:0] b, input logic [prod_w-1:0] exp,
                                   input logic [3:0] gap);
      stim_t s;
      s.name    = name;
      s.a       = a;
      s.b       = b;
      s.exp     = exp;
      s.has_exp = 1'b1;
      s.gap     = gap;
      return s;
   endfunction

   // ------------------------------
   // directed table
   // ------------------------------

   task automatic load_table();
      stims.push_back(entry("zero_a",    16'h0000, 16'h1234, 32'h0000_0000, 4'd0));
      stims.push_back(entry("zero_b",    16'hbeef, 16'h0000, 32'h0000_0000, 4'd1));
      stims.push_back(entry("one_x",     16'h0001, 16'ha5c3, 32'h0000_a5c3, 4'd0));
      stims.push_back(entry("x_one",     16'h7fff, 16'h0001, 32'h0000_7fff, 4'd2));
      stims.push_back(entry("max_max",   16'hffff, 16'hffff, 32'hfffe_0001, 4'd0));
      stims.push_back(entry("bit15_sq",  16'h8000, 16'h8000, 32'h4000_0000, 4'd1));
      stims.push_back(entry("bit0_15",   16'h0001, 16'h8000, 32'h0000_8000, 4'd0));
      stims.push_back(entry("bit8_sq",   16'h0100, 16'h0100, 32'h0001_0000, 4'd3));
      stims.push_back(entry("255x257",   16'h00ff, 16'h0101, 32'h0000_ffff, 4'd0));
      stims.push_back(entry("3x5555",    16'h0003, 16'h5555, 32'h0000_ffff, 4'd1));
      stims.push_back(entry("ffff_one",  16'hffff, 16'h0001, 32'h0000_ffff, 4'd2));
      // three strobes back to back
      stims.push_back(entry("b2b_a",     16'h1234, 16'h5678, 32'h0626_0060, 4'd0));
      stims.push_back(entry("b2b_b",     16'hffff, 16'h0002, 32'h0001_fffe, 4'd0));
      stims.push_back(entry("b2b_c",     16'h00ff, 16'h00ff, 32'h0000_fe01, 4'd4));
   endtask

   task automatic add_random(input int count);
      stim_t s;
      logic [31:0] r;
      for (int i = 0; i < count; i++) begin
         r = $random(seed);
         s.a = r[op_w-1:0];
         r = $random(seed);
         s.b = r[op_w-1:0];
         r = $random(seed);
         // shrink b now and then so both sides of overflow show up
         s.b       = s.b >> r[3:0];
         s.gap     = {2'b00, r[5:4]};
         s.name    = "random";
         s.exp     = '0;
         s.has_exp = 1'b0;
         stims.push_back(s);
      end
   endtask

   // called on a falling edge, returns on a falling edge
   task automatic drive_entry(input stim_t s);
      in_valid  = 1'b1;
      req.a     = s.a;
      req.b     = s.b;
      cur_name  = s.name;
      ref_prod  = s.exp;
      ref_given = s.has_exp;
      @(negedge clk);
      in_valid = 1'b0;
      repeat (s.gap) @(negedge clk);
   endtask

   // ------------------------------
   // main sequence
   // ------------------------------

   initial begin
      int budget;
      rst_n       = 1'b0;
      in_valid    = 1'b0;
      req         = '0;
      cur_name    = '0;
      ref_prod    = '0;
      ref_given   = 1'b0;
      end_of_test = 1'b0;
      budget      = 0;

      load_table();
      add_random(40);
      foreach (stims[i]) begin
         budget = budget + 1 + int'(stims[i].gap);
      end
      limit_cycles = budget + 20;

      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      // quiet period, nothing may come out
      repeat (3) @(negedge clk);

      foreach (stims[i]) begin
         drive_entry(stims[i]);
      end

      wait (pending == 0);
      repeat (3) @(negedge clk);
      end_of_test = 1'b1;
      @(negedge clk);

      $display("errors: %0d value, %0d protocol", value_errs, proto_errs);
      if (value_errs + proto_errs == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

   // watchdog
   initial begin
      wait (limit_cycles != 0);
      #(limit_cycles * 10);
      $display("timeout: the run did not finish within %0d cycles", limit_cycles);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

//--- csam_mul.f
hdl/csam_pkg.sv
hdl/csa_array.sv
hdl/cpa_saturate.sv
hdl/csam_mul.sv
testbench/csam_checker.sv
testbench/csam_mul_sva.sv
testbench/tb_csam_mul.sv

//--- Makefile
# Verilator build and run for the carry-save array multiplier

VERILATOR ?= verilator
TOP       ?= tb_csam_mul
FLIST     ?= csam_mul.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

# every source named in the file list, so edits trigger a rebuild
SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

FAIL_TEXT := FAIL: see errors above
PASS_TEXT := PASS: all tests

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
